//--- src/pipe_cfg.svh
/* width, register-number, NOP and reset-PC defines for the pipeline registers */

`ifndef PIPE_CFG_SVH
`define PIPE_CFG_SVH

// data, PC and instruction word width
`define PIPE_DATA_W 16

// register-file index width
`define PIPE_REG_W 4

// instruction word loaded into IF/ID on a flush
`define PIPE_NOP {`PIPE_DATA_W{1'b0}}

// PC held after reset or flush
`define PIPE_RESET_PC {`PIPE_DATA_W{1'b0}}

`endif

//--- src/pipe_pkg.sv
/* ALU op enum and the packed payload structs passed between pipeline stages */

`include "pipe_cfg.svh"

package pipe_pkg;

    typedef enum logic [0:0] {
        ALU_ADD = 1'b0,
        ALU_SUB = 1'b1
    } alu_op_e;

    // decode controls, EX group first, then MEM, WB and branch
    typedef struct packed {
        logic    reg_dst;
        logic    alu_src;
        alu_op_e alu_op;
        logic    mem_write;
        logic    mem_read;
        logic    mem_to_reg;
        logic    reg_write;
        logic    branch;
    } id_ctrl_t;

    typedef struct packed {
        id_ctrl_t                 ctrl;
        logic [`PIPE_DATA_W-1:0] src1;
        logic [`PIPE_DATA_W-1:0] src2;
        logic [`PIPE_DATA_W-1:0] sext;
        logic [`PIPE_REG_W-1:0]  rs;
        logic [`PIPE_REG_W-1:0]  rt;
        logic [`PIPE_REG_W-1:0]  rd;
    } id_bundle_t;

    // rd is resolved against rt when the bundle enters ID/EX
    typedef struct packed {
        id_ctrl_t                 ctrl;
        logic [`PIPE_DATA_W-1:0] src1;
        logic [`PIPE_DATA_W-1:0] src2;
        logic [`PIPE_DATA_W-1:0] sext;
        logic [`PIPE_REG_W-1:0]  rs;
        logic [`PIPE_REG_W-1:0]  rt;
        logic [`PIPE_REG_W-1:0]  dest;
    } id_ex_t;

    typedef struct packed {
        logic                     mem_write;
        logic                     mem_read;
        logic                     mem_to_reg;
        logic                     reg_write;
        logic [`PIPE_DATA_W-1:0] alu_out;
        logic [`PIPE_DATA_W-1:0] store_data;
        logic [`PIPE_REG_W-1:0]  dest;
    } ex_mem_t;

    // register-file write port
    typedef struct packed {
        logic                     en;
        logic [`PIPE_REG_W-1:0]  dest;
        logic [`PIPE_DATA_W-1:0] data;
    } wb_t;

endpackage

//--- src/hazard_ctrl.sv
/* load-use stall and taken-branch flush for the front of the pipeline */

`timescale 1ns/1ps

`include "pipe_cfg.svh"

module hazard_ctrl (
    input  pipe_pkg::id_ex_t        ex,
    input  logic [`PIPE_REG_W-1:0] id_rs,
    input  logic [`PIPE_REG_W-1:0] id_rt,
    input  logic                    branch_taken,
    output logic                    stall,
    output logic                    flush
);

    logic load_in_ex;
    logic dest_match;
    logic load_use;

    // a load in EX that writes a register the decoded instruction reads
    assign load_in_ex = ex.ctrl.mem_read & ex.ctrl.reg_write;
    assign dest_match = (ex.dest == id_rs) | (ex.dest == id_rt);
    assign load_use   = load_in_ex & dest_match;

    // a taken branch squashes the younger instructions anyway,
    // so the stall would only hold a wrong-path fetch
    assign stall = load_use & ~branch_taken;
    assign flush = branch_taken;

endmodule

//--- src/if_id_reg.sv
/* IF/ID register, PC+2 and instruction word with freeze and flush to NOP */

`timescale 1ns/1ps

`include "pipe_cfg.svh"

module if_id_reg (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     stall,
    input  logic                     flush,
    input  logic [`PIPE_DATA_W-1:0] if_pc,
    input  logic [`PIPE_DATA_W-1:0] if_instr,
    output logic [`PIPE_DATA_W-1:0] id_pc,
    output logic [`PIPE_DATA_W-1:0] id_instr
);

    always_ff @(posedge clk) begin
        if (rst) begin
            id_pc    <= '0;
            id_instr <= '0;
        end else if (flush) begin
            id_pc    <= `PIPE_RESET_PC;
            id_instr <= `PIPE_NOP;
        end else if (!stall) begin
            id_pc    <= if_pc;
            id_instr <= if_instr;
        end
        // stall holds the fetched instruction for another decode
    end

endmodule

//--- src/id_ex_reg.sv
/* ID/EX register with bubble insertion and destination register select */

`timescale 1ns/1ps

module id_ex_reg (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   bubble,
    input  pipe_pkg::id_bundle_t  id_in,
    output pipe_pkg::id_ex_t      ex
);

    pipe_pkg::id_ex_t ex_next;

    // R-type writes rd, everything else writes rt
    always_comb begin
        ex_next.ctrl = id_in.ctrl;
        ex_next.src1 = id_in.src1;
        ex_next.src2 = id_in.src2;
        ex_next.sext = id_in.sext;
        ex_next.rs   = id_in.rs;
        ex_next.rt   = id_in.rt;
        if (id_in.ctrl.reg_dst) begin
            ex_next.dest = id_in.rd;
        end else begin
            ex_next.dest = id_in.rt;
        end
    end

    // an all-zero entry has no write, load, store or branch
    always_ff @(posedge clk) begin
        if (rst) begin
            ex <= '0;
        end else if (bubble) begin
            ex <= '0;
        end else begin
            ex <= ex_next;
        end
    end

endmodule

//--- src/ex_mem_reg.sv
/* EX/MEM register with zero flag and taken-branch detection at MEM */

`timescale 1ns/1ps

`include "pipe_cfg.svh"

module ex_mem_reg (
    input  logic                     clk,
    input  logic                     rst,
    input  pipe_pkg::id_ex_t         ex,
    input  logic [`PIPE_DATA_W-1:0] ex_alu_out,
    input  logic [`PIPE_DATA_W-1:0] ex_store_data,
    output pipe_pkg::ex_mem_t        mem,
    output logic                     branch_taken
);

    logic zero;
    logic branch_q;
    logic zero_q;

    // compare result for beq style branches
    assign zero = (ex_alu_out == '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            mem      <= '0;
            branch_q <= 1'b0;
            zero_q   <= 1'b0;
        end else begin
            mem.mem_write  <= ex.ctrl.mem_write;
            mem.mem_read   <= ex.ctrl.mem_read;
            mem.mem_to_reg <= ex.ctrl.mem_to_reg;
            mem.reg_write  <= ex.ctrl.reg_write;
            mem.alu_out    <= ex_alu_out;
            mem.store_data <= ex_store_data;
            mem.dest       <= ex.dest;
            branch_q       <= ex.ctrl.branch;
            zero_q         <= zero;
        end
    end

    assign branch_taken = branch_q & zero_q;

endmodule

//--- src/mem_wb_reg.sv
/* MEM/WB register presenting the register-file write port */

`timescale 1ns/1ps

`include "pipe_cfg.svh"

module mem_wb_reg (
    input  logic                     clk,
    input  logic                     rst,
    input  pipe_pkg::ex_mem_t        mem,
    input  logic [`PIPE_DATA_W-1:0] mem_rdata,
    output pipe_pkg::wb_t            wb
);

    logic [`PIPE_DATA_W-1:0] wb_data;

    // loads take the memory word, all else the ALU result
    always_comb begin
        if (mem.mem_to_reg) begin
            wb_data = mem_rdata;
        end else begin
            wb_data = mem.alu_out;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wb <= '0;
        end else begin
            wb.en   <= mem.reg_write;
            wb.dest <= mem.dest;
            wb.data <= wb_data;
        end
    end

endmodule

//--- src/pipeline_regs.sv
/* pipeline register block, hazard controller and the IF/ID, ID/EX, EX/MEM
   and MEM/WB stage registers */

`timescale 1ns/1ps

`include "pipe_cfg.svh"

module pipeline_regs (
    input  logic                     clk,
    input  logic                     rst,
    // fetch
    input  logic [`PIPE_DATA_W-1:0] if_pc,
    input  logic [`PIPE_DATA_W-1:0] if_instr,
    // decode
    input  pipe_pkg::id_bundle_t     id_in,
    // execute
    input  logic [`PIPE_DATA_W-1:0] ex_alu_out,
    input  logic [`PIPE_DATA_W-1:0] ex_store_data,
    // memory
    input  logic [`PIPE_DATA_W-1:0] mem_rdata,
    output logic [`PIPE_DATA_W-1:0] id_pc,
    output logic [`PIPE_DATA_W-1:0] id_instr,
    output pipe_pkg::id_ex_t         ex,
    output pipe_pkg::ex_mem_t        mem,
    output pipe_pkg::wb_t            wb,
    output logic                     stall,
    output logic                     branch_taken
);

    logic flush;
    logic bubble;

    // both a load-use stall and a flush leave ID/EX empty
    assign bubble = stall | flush;

    hazard_ctrl i_hazard_ctrl (
        .ex           (ex),
        .id_rs        (id_in.rs),
        .id_rt        (id_in.rt),
        .branch_taken (branch_taken),
        .stall        (stall),
        .flush        (flush)
    );

    if_id_reg i_if_id_reg (
        .clk      (clk),
        .rst      (rst),
        .stall    (stall),
        .flush    (flush),
        .if_pc    (if_pc),
        .if_instr (if_instr),
        .id_pc    (id_pc),
        .id_instr (id_instr)
    );

    id_ex_reg i_id_ex_reg (
        .clk    (clk),
        .rst    (rst),
        .bubble (bubble),
        .id_in  (id_in),
        .ex     (ex)
    );

    ex_mem_reg i_ex_mem_reg (
        .clk           (clk),
        .rst           (rst),
        .ex            (ex),
        .ex_alu_out    (ex_alu_out),
        .ex_store_data (ex_store_data),
        .mem           (mem),
        .branch_taken  (branch_taken)
    );

    mem_wb_reg i_mem_wb_reg (
        .clk       (clk),
        .rst       (rst),
        .mem       (mem),
        .mem_rdata (mem_rdata),
        .wb        (wb)
    );

endmodule

//--- verif/pipeline_regs_tb.sv
/* testbench for pipeline_regs: reference model of the four stage registers and
   hazard rules, directed and random stimulus, compare task and watchdog */

`timescale 1ns/1ps

`include "pipe_cfg.svh"

module pipeline_regs_tb;

    localparam int CLK_PERIOD    = 40;
    localparam int CLEAN_CYCLES  = 150;
    localparam int MIXED_CYCLES  = 400;
    localparam int TEST_CYCLES   = 2 + 40 + CLEAN_CYCLES + MIXED_CYCLES;

    // expected contents of every pipeline register
    typedef struct packed {
        logic [`PIPE_DATA_W-1:0] id_pc;
        logic [`PIPE_DATA_W-1:0] id_instr;
        pipe_pkg::id_ex_t        ex;
        pipe_pkg::ex_mem_t       mem;
        logic                    branch_q;
        logic                    zero_q;
        pipe_pkg::wb_t           wb;
    } model_t;

    logic                    clk;
    logic                    rst;
    logic [`PIPE_DATA_W-1:0] if_pc;
    logic [`PIPE_DATA_W-1:0] if_instr;
    pipe_pkg::id_bundle_t    id_in;
    logic [`PIPE_DATA_W-1:0] ex_alu_out;
    logic [`PIPE_DATA_W-1:0] ex_store_data;
    logic [`PIPE_DATA_W-1:0] mem_rdata;
    logic [`PIPE_DATA_W-1:0] id_pc;
    logic [`PIPE_DATA_W-1:0] id_instr;
    pipe_pkg::id_ex_t        ex;
    pipe_pkg::ex_mem_t       mem;
    pipe_pkg::wb_t           wb;
    logic                    stall;
    logic                    branch_taken;

    model_t model = '0;
    logic   front_held = 1'b0;

    pipeline_regs i_pipeline_regs (
        .clk           (clk),
        .rst           (rst),
        .if_pc         (if_pc),
        .if_instr      (if_instr),
        .id_in         (id_in),
        .ex_alu_out    (ex_alu_out),
        .ex_store_data (ex_store_data),
        .mem_rdata     (mem_rdata),
        .id_pc         (id_pc),
        .id_instr      (id_instr),
        .ex            (ex),
        .mem           (mem),
        .wb            (wb),
        .stall         (stall),
        .branch_taken  (branch_taken)
    );

    task automatic check(input string name, input logic [71:0] expected,
                         input logic [71:0] actual);
        if (actual !== expected) begin
            $display("Error: time %0t, %s expected %h actual %h", $time, name, expected, actual);
            $display("** FAIL **");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    // load-use stall, suppressed by a taken branch at MEM
    function automatic logic ref_stall(input model_t s, input pipe_pkg::id_bundle_t d);
        logic load_use;
        load_use = s.ex.ctrl.mem_read & s.ex.ctrl.reg_write
                   & ((s.ex.dest == d.rs) | (s.ex.dest == d.rt));
        return load_use & ~(s.branch_q & s.zero_q);
    endfunction

    function automatic model_t ref_step(input model_t s, input logic rst_in,
                                        input logic [`PIPE_DATA_W-1:0] pc,
                                        input logic [`PIPE_DATA_W-1:0] instr,
                                        input pipe_pkg::id_bundle_t d,
                                        input logic [`PIPE_DATA_W-1:0] alu,
                                        input logic [`PIPE_DATA_W-1:0] store,
                                        input logic [`PIPE_DATA_W-1:0] rdata);
        model_t n;
        logic   taken;
        logic   hold;
        n     = s;
        taken = s.branch_q & s.zero_q;
        hold  = ref_stall(s, d);
        if (taken) begin
            n.id_pc    = '0;
            n.id_instr = '0;
        end else if (!hold) begin
            n.id_pc    = pc;
            n.id_instr = instr;
        end
        if (taken || hold) begin
            n.ex = '0;
        end else begin
            n.ex.ctrl = d.ctrl;
            n.ex.src1 = d.src1;
            n.ex.src2 = d.src2;
            n.ex.sext = d.sext;
            n.ex.rs   = d.rs;
            n.ex.rt   = d.rt;
            n.ex.dest = d.ctrl.reg_dst ? d.rd : d.rt;
        end
        n.mem.mem_write  = s.ex.ctrl.mem_write;
        n.mem.mem_read   = s.ex.ctrl.mem_read;
        n.mem.mem_to_reg = s.ex.ctrl.mem_to_reg;
        n.mem.reg_write  = s.ex.ctrl.reg_write;
        n.mem.alu_out    = alu;
        n.mem.store_data = store;
        n.mem.dest       = s.ex.dest;
        n.branch_q       = s.ex.ctrl.branch;
        n.zero_q         = (alu == '0);
        n.wb.en          = s.mem.reg_write;
        n.wb.dest        = s.mem.dest;
        n.wb.data        = s.mem.mem_to_reg ? rdata : s.mem.alu_out;
        if (rst_in) begin
            n = '0;
        end
        return n;
    endfunction

    // narrow register numbers make load-use hazards frequent
    function automatic pipe_pkg::id_bundle_t random_bundle(input bit with_hazards);
        pipe_pkg::id_bundle_t b;
        logic [95:0]          raw;
        raw = {$urandom, $urandom, $urandom};
        b   = raw[$bits(pipe_pkg::id_bundle_t)-1:0];
        if (with_hazards) begin
            b.rs = 4'($urandom_range(0, 3));
            b.rt = 4'($urandom_range(0, 3));
            b.rd = 4'($urandom_range(0, 3));
        end else begin
            b.ctrl.mem_read = 1'b0;
            b.ctrl.branch   = 1'b0;
        end
        return b;
    endfunction

    // front inputs stay put after a stall edge so the held IF/ID is decoded again
    task automatic drive_cycle(input logic [`PIPE_DATA_W-1:0] pc,
                               input logic [`PIPE_DATA_W-1:0] instr,
                               input pipe_pkg::id_bundle_t bundle,
                               input logic [`PIPE_DATA_W-1:0] alu);
        @(negedge clk);
        if (!front_held) begin
            if_pc    = pc;
            if_instr = instr;
            id_in    = bundle;
        end
        ex_alu_out    = alu;
        ex_store_data = 16'($urandom);
        mem_rdata     = 16'($urandom);
    endtask

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    initial begin
        #(2 * TEST_CYCLES * CLK_PERIOD);
        $display("Error: the run timed out after %0d cycles without finishing", 2 * TEST_CYCLES);
        $display("** FAIL **");
        $fatal(1, "watchdog expired");
    end

    // combinational outputs just before the edge, registers just after it
    initial begin
        forever begin
            @(negedge clk);
            #(CLK_PERIOD / 2 - 2);
            check("stall", ref_stall(model, id_in), stall);
            check("branch_taken", model.branch_q & model.zero_q, branch_taken);
            @(posedge clk);
            front_held = ref_stall(model, id_in) & ~rst;
            model = ref_step(model, rst, if_pc, if_instr, id_in, ex_alu_out,
                             ex_store_data, mem_rdata);
            #1;
            check("id_pc", model.id_pc, id_pc);
            check("id_instr", model.id_instr, id_instr);
            check("ex", model.ex, ex);
            check("mem", model.mem, mem);
            check("wb", model.wb, wb);
        end
    end

    initial begin
        pipe_pkg::id_bundle_t lw;
        pipe_pkg::id_bundle_t dep;
        pipe_pkg::id_bundle_t br;
        void'($urandom(32'hcfb8_adfc));
        rst           = 1'b1;
        if_pc         = '0;
        if_instr      = '0;
        id_in         = '0;
        ex_alu_out    = '0;
        ex_store_data = '0;
        mem_rdata     = '0;
        repeat (2) @(negedge clk);
        rst = 1'b0;
        #1;
        check("id_instr", `PIPE_NOP, id_instr);
        check("id_pc", `PIPE_RESET_PC, id_pc);
        check("ex", '0, ex);
        check("mem", '0, mem);
        check("wb", '0, wb);
        check("stall", 1'b0, stall);
        check("branch_taken", 1'b0, branch_taken);

        // load into r5 followed by a reader of r5
        lw                 = '0;
        lw.ctrl.mem_read   = 1'b1;
        lw.ctrl.reg_write  = 1'b1;
        lw.ctrl.mem_to_reg = 1'b1;
        lw.ctrl.alu_src    = 1'b1;
        lw.rs              = 4'd1;
        lw.rt              = 4'd5;
        lw.rd              = 4'd9;
        dep                = '0;
        dep.ctrl.reg_write = 1'b1;
        dep.ctrl.reg_dst   = 1'b1;
        dep.rs             = 4'd5;
        dep.rt             = 4'd2;
        dep.rd             = 4'd3;
        drive_cycle(16'h0002, 16'h8150, lw, 16'h0040);
        drive_cycle(16'h0004, 16'h0523, dep, 16'h1234);
        #1;
        check("stall", 1'b1, stall);
        @(posedge clk);
        #1;
        check("id_pc", 16'h0002, id_pc);
        check("id_instr", 16'h8150, id_instr);
        check("ex", '0, ex);
        drive_cycle(16'h0006, 16'h0000, '0, 16'h0001);
        drive_cycle(16'h0008, 16'h0000, '0, 16'h0002);

        // taken branch at MEM wins over a load-use hazard in the same cycle
        br               = '0;
        br.ctrl.branch   = 1'b1;
        br.ctrl.alu_op   = pipe_pkg::ALU_SUB;
        br.rs            = 4'd1;
        br.rt            = 4'd2;
        lw.rt            = 4'd6;
        dep.rs           = 4'd6;
        drive_cycle(16'h000a, 16'h7120, br, 16'h0003);
        drive_cycle(16'h000c, 16'h8160, lw, 16'h0000);
        drive_cycle(16'h000e, 16'h0623, dep, 16'h0055);
        #1;
        check("branch_taken", 1'b1, branch_taken);
        check("stall", 1'b0, stall);
        @(posedge clk);
        #1;
        check("id_instr", `PIPE_NOP, id_instr);
        check("id_pc", `PIPE_RESET_PC, id_pc);
        check("ex", '0, ex);

        // branch with a nonzero compare result falls through
        drive_cycle(16'h0010, 16'h7120, br, 16'h0004);
        drive_cycle(16'h0012, 16'h0000, '0, 16'h0011);
        drive_cycle(16'h0014, 16'h0000, '0, 16'h0005);
        #1;
        check("branch_taken", 1'b0, branch_taken);

        repeat (CLEAN_CYCLES) begin
            drive_cycle(16'($urandom), 16'($urandom), random_bundle(1'b0), 16'($urandom));
        end
        repeat (MIXED_CYCLES) begin
            drive_cycle(16'($urandom), 16'($urandom), random_bundle(1'b1),
                        ($urandom_range(0, 3) == 0) ? 16'h0000 : 16'($urandom));
        end

        repeat (3) @(posedge clk);
        #2;
        $display("** PASS **");
        $finish;
    end

endmodule

//--- project.f
+incdir+src
src/pipe_pkg.sv
src/hazard_ctrl.sv
src/if_id_reg.sv
src/id_ex_reg.sv
src/ex_mem_reg.sv
src/mem_wb_reg.sv
src/pipeline_regs.sv
verif/pipeline_regs_tb.sv
